//--- common/fetch_pkg.sv
/*
 * Shared types and constants of the instruction-fetch front end.
 * Words are 32 bits and instruction addresses are word aligned.
 * Any error tag outside the TLB-miss and page-fault codes counts as a bus error.
 * Vector addresses are absolute; no vector base register exists.
 */

`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////////////////////

	// instruction or address word
	typedef logic [31:0] word_t;

	// error tag from the instruction memory
	typedef logic [3:0] tag_t;

	// exception code toward the control block
	typedef enum logic [1:0] {
		EXC_NONE       = 2'd0,
		EXC_TLB_MISS   = 2'd1,
		EXC_PAGE_FAULT = 2'd2,
		EXC_BUS_ERR    = 2'd3
	} exc_e;

	////////////////////////////////////////////////////////////////////////////
	// constants
	////////////////////////////////////////////////////////////////////////////

	// tag codes as the memory reports them
	localparam tag_t TAG_TLB_MISS   = 4'hd;
	localparam tag_t TAG_PAGE_FAULT = 4'hc;
	localparam tag_t TAG_BUS_ERR    = 4'hb;

	// exception vectors
	localparam word_t VEC_TLB_MISS   = 32'h0000_0a00;
	localparam word_t VEC_PAGE_FAULT = 32'h0000_0400;
	localparam word_t VEC_BUS_ERR    = 32'h0000_0200;

	// handed to decode whenever no valid word is present
	localparam word_t INSN_NOP = 32'h1500_0000;

endpackage

`default_nettype wire

//--- common/icpu_intf.sv
/*
 * Response side of the instruction-memory port.
 * The memory drives all five signals; ack and err are single-cycle pulses
 * and are never high together. adr echoes the address being answered.
 */

`default_nettype none

interface icpu_intf;

	import fetch_pkg::*;

	// returned instruction word
	word_t dat;
	// response strobes
	logic ack;
	logic err;
	// echoed request address
	word_t adr;
	// error tag, meaningful with err only
	tag_t tag;

	// memory side
	modport mem (output dat, output ack, output err, output adr, output tag);

	// fetch stage side
	modport cpu (input dat, input ack, input err, input adr, input tag);

endinterface

`default_nettype wire

//--- fetch/genpc.sv
/*
 * Program counter and request strobe for the instruction memory.
 * Only one request is outstanding; adr_o stays put until ack or err,
 * except on a redirect, which marks the old response as stale.
 * req_o drops while a frozen response is held and after an err,
 * until the exception redirect arrives.
 */

`default_nettype none

module genpc #(
	parameter fetch_pkg::word_t RESET_PC = 32'h0000_0100
) (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             ack_i,
	input  logic             err_i,
	input  logic             freeze_i,
	input  logic             flush_i,
	input  fetch_pkg::word_t redirect_pc_i,
	input  logic             refetch_i,
	output logic             req_o,
	output fetch_pkg::word_t adr_o,
	output logic             discard_o
);

	import fetch_pkg::*;

	logic  resp;
	logic  req_q;
	word_t pc_q;
	// response in flight is for an address before the last redirect
	logic  discard_q;
	// a frozen response sits in the fetch stage
	logic  hold_q;
	logic  held_err_q;
	// err taken, waiting for the vector
	logic  wait_q;

	assign resp      = ack_i | err_i;
	assign req_o     = req_q & !hold_q & !wait_q;
	assign adr_o     = pc_q;
	assign discard_o = discard_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			req_q      <= 1'b0;
			pc_q       <= RESET_PC;
			discard_q  <= 1'b0;
			hold_q     <= 1'b0;
			held_err_q <= 1'b0;
			wait_q     <= 1'b0;
		end else begin
			// first request goes out one cycle after reset
			req_q <= 1'b1;
			if (flush_i) begin
				pc_q      <= redirect_pc_i;
				hold_q    <= 1'b0;
				wait_q    <= 1'b0;
				// old request still open, drop its answer
				discard_q <= (req_o | discard_q) & !resp;
			end else if (discard_q) begin
				if (resp)
					discard_q <= 1'b0;
			end else if (hold_q) begin
				// saved word goes to decode in the cycle freeze ends
				if (!freeze_i) begin
					hold_q <= 1'b0;
					if (held_err_q)
						wait_q <= 1'b1;
					else
						pc_q <= pc_q + 32'd4;
				end
			end else if (resp && req_o && !refetch_i) begin
				if (freeze_i) begin
					hold_q     <= 1'b1;
					held_err_q <= err_i;
				end else if (err_i) begin
					wait_q <= 1'b1;
				end else begin
					pc_q <= pc_q + 32'd4;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- fetch/if_stage.sv
/*
 * Fetch stage between the instruction memory and decode.
 * A response arriving under freeze is saved and shown in the first
 * unfrozen cycle; only one response can be saved at a time.
 * Outputs are combinational from the live response or the saved copy.
 */

`default_nettype none

module if_stage (
	input  logic             clk,
	input  logic             rst_n_i,
	icpu_intf.cpu            icpu,
	input  logic             freeze_i,
	input  logic             flush_i,
	input  logic             discard_i,
	output logic             valid_o,
	output fetch_pkg::word_t insn_o,
	output fetch_pkg::word_t pc_o,
	output logic             refetch_o,
	output fetch_pkg::exc_e  except_o
);

	import fetch_pkg::*;

	logic  resp;
	// response that belongs to the current request
	logic  live;
	logic  live_ack;
	logic  save;
	// stage may hand something to decode
	logic  open;
	logic  saved_q;
	word_t insn_saved_q;
	word_t addr_saved_q;
	exc_e  exc_saved_q;

	// tag decode, unknown tags end up as bus errors
	function automatic exc_e classify(input tag_t tag);
		case (tag)
			TAG_TLB_MISS:   return EXC_TLB_MISS;
			TAG_PAGE_FAULT: return EXC_PAGE_FAULT;
			default:        return EXC_BUS_ERR;
		endcase
	endfunction

	assign resp     = icpu.ack | icpu.err;
	assign live     = resp & !discard_i & !flush_i;
	assign live_ack = live & icpu.ack & !icpu.err;
	assign save     = live & freeze_i & !saved_q;
	assign open     = !freeze_i & !flush_i;

	////////////////////////////////////////////////////////////////////////////
	// saved copy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			saved_q     <= 1'b0;
			exc_saved_q <= EXC_NONE;
		end else if (flush_i || (!freeze_i && !save)) begin
			saved_q     <= 1'b0;
			exc_saved_q <= EXC_NONE;
		end else if (save) begin
			saved_q     <= 1'b1;
			exc_saved_q <= icpu.err ? classify(icpu.tag) : EXC_NONE;
		end
	end

	// payload, qualified by saved_q
	always_ff @(posedge clk) begin
		if (save) begin
			insn_saved_q <= icpu.dat;
			addr_saved_q <= {icpu.adr[31:2], 2'b00};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// outputs toward decode
	////////////////////////////////////////////////////////////////////////////

	// saved copy wins over anything live
	assign valid_o = open & (saved_q ? (exc_saved_q == EXC_NONE) : live_ack);

	always_comb begin
		if (!open)
			except_o = EXC_NONE;
		else if (saved_q)
			except_o = exc_saved_q;
		else if (live && icpu.err)
			except_o = classify(icpu.tag);
		else
			except_o = EXC_NONE;
	end

	assign insn_o = !valid_o ? INSN_NOP : (saved_q ? insn_saved_q : icpu.dat);
	assign pc_o   = saved_q ? addr_saved_q : {icpu.adr[31:2], 2'b00};

	// ack on top of a saved word is a repeat, not a new word
	assign refetch_o = saved_q & icpu.ack & !discard_i;

endmodule

`default_nettype wire

//--- fetch/fetch_ctrl.sv
/*
 * Freeze and flush control of the fetch front end.
 * An exception redirects fetch one cycle after it is shown; an external
 * flush in that cycle takes priority over the vector.
 * epcr holds the PC of the last faulting fetch until the next fault.
 */

`default_nettype none

module fetch_ctrl (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             freeze_i,
	input  logic             flush_i,
	input  fetch_pkg::word_t flush_pc_i,
	input  fetch_pkg::exc_e  except_i,
	input  fetch_pkg::word_t pc_i,
	output logic             if_freeze_o,
	output logic             if_flush_o,
	output fetch_pkg::word_t redirect_pc_o,
	output fetch_pkg::exc_e  except_o,
	output fetch_pkg::word_t epcr_o
);

	import fetch_pkg::*;

	// exception seen last cycle, drives the redirect
	exc_e  exc_q;
	word_t epcr_q;

	function automatic word_t vector_of(input exc_e code);
		case (code)
			EXC_TLB_MISS:   return VEC_TLB_MISS;
			EXC_PAGE_FAULT: return VEC_PAGE_FAULT;
			default:        return VEC_BUS_ERR;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// exception capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			exc_q <= EXC_NONE;
		else
			exc_q <= except_i;
	end

	// faulting fetch address
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			epcr_q <= '0;
		else if (except_i != EXC_NONE)
			epcr_q <= pc_i;
	end

	////////////////////////////////////////////////////////////////////////////
	// freeze, flush and redirect
	////////////////////////////////////////////////////////////////////////////

	// freeze goes straight through to both blocks
	assign if_freeze_o = freeze_i;

	// external flush or exception redirect
	assign if_flush_o = flush_i | (exc_q != EXC_NONE);

	// external target first
	assign redirect_pc_o = flush_i ? flush_pc_i : vector_of(exc_q);

	// same-cycle report of the fault
	assign except_o = except_i;
	assign epcr_o   = epcr_q;

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
/*
 * Instruction-fetch front end with plain ports.
 * The memory must answer each request with one cycle of ack or err and
 * echo the request address; one request is outstanding at a time.
 * RESET_PC must be word aligned.
 */

`default_nettype none

module fetch_top #(
	parameter fetch_pkg::word_t RESET_PC = 32'h0000_0100
) (
	input  logic             clk,
	input  logic             rst_n_i,
	input  fetch_pkg::word_t icpu_dat_i,
	input  logic             icpu_ack_i,
	input  logic             icpu_err_i,
	input  fetch_pkg::word_t icpu_adr_i,
	input  fetch_pkg::tag_t  icpu_tag_i,
	input  logic             freeze_i,
	input  logic             flush_i,
	input  fetch_pkg::word_t flush_pc_i,
	output logic             icpu_req_o,
	output fetch_pkg::word_t icpu_adr_o,
	output logic             if_valid_o,
	output fetch_pkg::word_t if_insn_o,
	output fetch_pkg::word_t if_pc_o,
	output fetch_pkg::exc_e  except_o,
	output fetch_pkg::word_t epcr_o
);

	import fetch_pkg::*;

	logic  if_freeze;
	logic  if_flush;
	word_t redirect_pc;
	logic  discard;
	logic  refetch;
	exc_e  except_code;

	// memory response bundle
	icpu_intf icpu ();

	assign icpu.dat = icpu_dat_i;
	assign icpu.ack = icpu_ack_i;
	assign icpu.err = icpu_err_i;
	assign icpu.adr = icpu_adr_i;
	assign icpu.tag = icpu_tag_i;

	genpc #(
		.RESET_PC (RESET_PC)
	) genpc_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.ack_i         (icpu_ack_i),
		.err_i         (icpu_err_i),
		.freeze_i      (if_freeze),
		.flush_i       (if_flush),
		.redirect_pc_i (redirect_pc),
		.refetch_i     (refetch),
		.req_o         (icpu_req_o),
		.adr_o         (icpu_adr_o),
		.discard_o     (discard)
	);

	if_stage if_stage_i (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.icpu      (icpu.cpu),
		.freeze_i  (if_freeze),
		.flush_i   (if_flush),
		.discard_i (discard),
		.valid_o   (if_valid_o),
		.insn_o    (if_insn_o),
		.pc_o      (if_pc_o),
		.refetch_o (refetch),
		.except_o  (except_code)
	);

	fetch_ctrl fetch_ctrl_i (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.freeze_i      (freeze_i),
		.flush_i       (flush_i),
		.flush_pc_i    (flush_pc_i),
		.except_i      (except_code),
		.pc_i          (if_pc_o),
		.if_freeze_o   (if_freeze),
		.if_flush_o    (if_flush),
		.redirect_pc_o (redirect_pc),
		.except_o      (except_o),
		.epcr_o        (epcr_o)
	);

endmodule

`default_nettype wire

//--- testbench/fetch_properties.sv
/*
 * Fetch protocol checks, bound into fetch_top.
 * Address stability is not checked across a flush, since a flush
 * may redirect a request that is still open.
 */

`default_nettype none

module fetch_properties (
	input logic             clk,
	input logic             rst_n_i,
	input logic             req_i,
	input fetch_pkg::word_t adr_i,
	input logic             ack_i,
	input logic             err_i,
	input logic             flush_i,
	input logic             valid_i,
	input fetch_pkg::word_t insn_i,
	input fetch_pkg::exc_e  except_i
);

	import fetch_pkg::*;

	// decode never sees a word and a fault together
	one_output: assert property (@(posedge clk) disable iff (!rst_n_i)
		!(valid_i && except_i != EXC_NONE))
		else $error("if_valid_o and except_o high together");

	// open request keeps its address
	adr_steady: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_i && !ack_i && !err_i && !flush_i |=> $stable(adr_i))
		else $error("icpu_adr_o changed while a request was open");

	// first request right after reset
	req_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |=> req_i)
		else $error("no request in the cycle after reset");

	nop_when_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
		!valid_i |-> insn_i == INSN_NOP)
		else $error("if_insn_o is not the NOP word while if_valid_o is low");

endmodule

bind fetch_top fetch_properties fetch_properties_i (
	.clk      (clk),
	.rst_n_i  (rst_n_i),
	.req_i    (icpu_req_o),
	.adr_i    (icpu_adr_o),
	.ack_i    (icpu_ack_i),
	.err_i    (icpu_err_i),
	.flush_i  (flush_i),
	.valid_i  (if_valid_o),
	.insn_i   (if_insn_o),
	.except_i (except_o)
);

`default_nettype wire

//--- testbench/fetch_tb.sv
/*
 * Testbench of the fetch front end, acting as the instruction memory.
 * Cases come from testbench/fetch_cases.txt, one 72-bit hex entry per line.
 * Each case serves exactly one request; the simulation runs from the project root.
 * Latency jitter of 0 to 2 cycles comes from $urandom with a fixed seed.
 */

`default_nettype none

module fetch_tb;

	import fetch_pkg::*;

	parameter int SEED = 86;

	localparam word_t RESET_PC = 32'h0000_0100;
	localparam int MAX_CASES = 64;

	// case kinds, upper nibble of an entry
	localparam logic [3:0] K_ACK    = 4'h1;
	localparam logic [3:0] K_ERR    = 4'h2;
	localparam logic [3:0] K_FREEZE = 4'h3;
	localparam logic [3:0] K_FLUSH  = 4'h4;

	logic  clk;
	logic  rst_n_i;
	word_t icpu_dat_i;
	logic  icpu_ack_i;
	logic  icpu_err_i;
	word_t icpu_adr_i;
	tag_t  icpu_tag_i;
	logic  freeze_i;
	logic  flush_i;
	word_t flush_pc_i;
	logic  icpu_req_o;
	word_t icpu_adr_o;
	logic  if_valid_o;
	word_t if_insn_o;
	word_t if_pc_o;
	exc_e  except_o;
	word_t epcr_o;

	// kind, latency, data or tag, freeze length or flush target
	logic [71:0] cases [0:MAX_CASES-1];
	int    n_cases;
	int    limit;
	int    cycle_cnt;
	int    mism;
	int    fails;
	int    frz_left;
	// reference model of the PC stream
	word_t exp_pc;

	fetch_top #(
		.RESET_PC (RESET_PC)
	) fetch_top_i (.*);

	always #20 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		if (rst_n_i && limit > 0) begin
			cycle_cnt = cycle_cnt + 1;
			if (cycle_cnt > limit) begin
				$display("timeout after %0d cycles, fetch made no progress", cycle_cnt);
				$display("Test failed");
				$finish;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// expected values from the tag and vector rules
	////////////////////////////////////////////////////////////////////////////

	function automatic exc_e code_of_tag(input tag_t tag);
		if (tag == TAG_TLB_MISS)
			return EXC_TLB_MISS;
		if (tag == TAG_PAGE_FAULT)
			return EXC_PAGE_FAULT;
		return EXC_BUS_ERR;
	endfunction

	function automatic word_t vector_for(input exc_e code);
		if (code == EXC_TLB_MISS)
			return VEC_TLB_MISS;
		if (code == EXC_PAGE_FAULT)
			return VEC_PAGE_FAULT;
		return VEC_BUS_ERR;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// cycle helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("MISMATCH %s: got %h expected %h", name, got, want);
			mism++;
		end
	endtask

	// advance to the drive point of the next cycle with the memory idle
	task automatic next_cycle();
		@(posedge clk);
		#2;
		icpu_ack_i = 1'b0;
		icpu_err_i = 1'b0;
		flush_i    = 1'b0;
		freeze_i   = (frz_left > 0);
		if (frz_left > 0)
			frz_left--;
	endtask

	// look late in the cycle once outputs have settled
	task automatic sample();
		@(negedge clk);
		if (!if_valid_o)
			compare("if_insn_o", if_insn_o, INSN_NOP);
		if (freeze_i && if_valid_o) begin
			$display("word delivered while freeze_i is high, pc %h", if_pc_o);
			fails++;
		end
	endtask

	task automatic expect_quiet();
		sample();
		compare("if_valid_o", 32'(if_valid_o), 32'd0);
		compare("except_o", 32'(except_o), 32'(EXC_NONE));
	endtask

	// one delivered word at the expected PC
	task automatic expect_word(input word_t data);
		sample();
		compare("if_valid_o", 32'(if_valid_o), 32'd1);
		compare("if_pc_o", if_pc_o, exp_pc);
		compare("if_insn_o", if_insn_o, data);
		exp_pc = exp_pc + 32'd4;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// one case against one request
	////////////////////////////////////////////////////////////////////////////

	task automatic run_case(input int idx);
		logic [3:0] kind;
		logic [3:0] lat;
		word_t      value;
		word_t      target;
		word_t      req_adr;
		int         delay;
		exc_e       code;
		kind   = cases[idx][71:68];
		lat    = cases[idx][67:64];
		value  = cases[idx][63:32];
		target = cases[idx][31:0];
		while (!icpu_req_o) begin
			expect_quiet();
			next_cycle();
		end
		// memory latches the address of the open request
		req_adr = icpu_adr_o;
		compare("icpu_adr_o", req_adr, exp_pc);
		delay = int'(lat) + int'($urandom % 3);
		if (kind == K_FREEZE) begin
			freeze_i = 1'b1;
			frz_left = int'(target) - 1;
		end
		if (kind == K_FLUSH) begin
			flush_i    = 1'b1;
			flush_pc_i = target;
		end
		for (int k = 0; k < delay; k++) begin
			if (k > 0)
				next_cycle();
			expect_quiet();
		end
		// response cycle
		next_cycle();
		icpu_adr_i = req_adr;
		icpu_dat_i = value;
		icpu_tag_i = value[3:0];
		if (kind == K_ERR)
			icpu_err_i = 1'b1;
		else
			icpu_ack_i = 1'b1;
		case (kind)
			K_ACK, K_FREEZE: begin
				// held word shows up in the first unfrozen cycle
				if (freeze_i) begin
					expect_quiet();
					next_cycle();
					while (freeze_i) begin
						expect_quiet();
						next_cycle();
					end
				end
				expect_word(value);
			end
			K_ERR: begin
				code = code_of_tag(value[3:0]);
				sample();
				compare("if_valid_o", 32'(if_valid_o), 32'd0);
				compare("except_o", 32'(except_o), 32'(code));
				next_cycle();
				expect_quiet();
				compare("epcr_o", epcr_o, exp_pc);
				exp_pc = vector_for(code);
			end
			default: begin
				// stale answer is dropped
				expect_quiet();
				exp_pc = target;
			end
		endcase
		next_cycle();
	endtask

	initial begin
		clk        = 1'b0;
		rst_n_i    = 1'b0;
		icpu_dat_i = '0;
		icpu_ack_i = 1'b0;
		icpu_err_i = 1'b0;
		icpu_adr_i = '0;
		icpu_tag_i = '0;
		freeze_i   = 1'b0;
		flush_i    = 1'b0;
		flush_pc_i = '0;
		frz_left   = 0;
		cycle_cnt  = 0;
		limit      = 0;
		mism       = 0;
		fails      = 0;
		exp_pc     = RESET_PC;
		void'($urandom(SEED));
		for (int i = 0; i < MAX_CASES; i++)
			cases[i] = '0;
		$readmemh("testbench/fetch_cases.txt", cases);
		n_cases = 0;
		while (n_cases < MAX_CASES && cases[n_cases][71:68] != 4'h0)
			n_cases++;
		if (n_cases == 0) begin
			$display("no cases read from testbench/fetch_cases.txt");
			fails++;
		end
		limit = n_cases * 20;
		repeat (5) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		// nothing is requested in the release cycle
		compare("icpu_req_o", 32'(icpu_req_o), 32'd0);
		expect_quiet();
		next_cycle();
		for (int i = 0; i < n_cases; i++)
			run_case(i);
		$display("checks done: %0d mismatches, %0d other errors", mism, fails);
		if (mism + fails == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/fetch_cases.txt
// kind_latency_value_target: kind 1 ack, 2 err, 3 ack under freeze, 4 flush in flight
// value is the word, the tag (err) or the stale word (flush); target is freeze cycles or flush PC
1_3_13570001_00000000
1_1_13570002_00000000
1_8_13570003_00000000
3_2_2468000a_0000000c
1_1_13570004_00000000
2_2_0000000d_00000000
1_4_13570005_00000000
4_5_deadbeef_00002000
1_2_13570006_00000000
2_1_0000000c_00000000
1_1_13570007_00000000
3_4_2468000b_0000000e
2_3_0000000b_00000000
1_6_13570008_00000000
2_2_00000007_00000000
1_1_13570009_00000000
4_1_deadbeef_00003000
1_2_1357000a_00000000
3_1_2468000c_00000003
1_3_1357000b_00000000

//--- sim.f
common/fetch_pkg.sv
common/icpu_intf.sv
fetch/genpc.sv
fetch/if_stage.sv
fetch/fetch_ctrl.sv
rtl/fetch_top.sv
testbench/fetch_properties.sv
testbench/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

TOP       ?= fetch_tb
LOG       ?= sim.log
SEED      ?= 86
MDIR      ?= obj_dir
VERILATOR ?= verilator

VFLAGS = --binary --timing --assert -f sim.f --top-module $(TOP) -GSEED=$(SEED) -Mdir $(MDIR)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS)
	./$(MDIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Test failed" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
